/* compile.f */
common/lsu_pkg.sv
store_buffer/sb_entry.sv
store_buffer/store_buffer.sv
design/sb_forward.sv
design/dcache_array.sv
design/lsu_store_path.sv
tests/tb_lsu_store_path.sv

/* run.sh */
#!/bin/sh
# build and run the store path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_lsu_store_path \
  -o sim_tb_lsu_store_path

# the simulation output goes to the terminal and through grep
if ./obj_dir/sim_tb_lsu_store_path | tee /dev/stderr | grep -x "No errors" > /dev/null; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* tests/tb_lsu_store_path.sv */
// self-checking testbench; assumes IDX_W of 4 and one address per line index, no evictions
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_store_path
  import lsu_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int IN_DELAY        = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int DEPTH           = SB_DEPTH_DEF;
  localparam int IDX_W           = LINE_IDX_W;
  localparam int LINES           = 1 << IDX_W;
  localparam int RANDOM_CYCLES   = 400;
  // five directed tests including their waits
  localparam int DIRECTED_CYCLES = 100;
  localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  mask;
    logic        hit;
  } exp_load_t;

  logic        clk;
  logic        arst_n_i;
  logic        st_valid_i;
  sb_meta_t    st_req_i;
  logic        st_ready_o;
  logic        ld_valid_i;
  addr_t       ld_addr_i;
  logic        ld_valid_o;
  ld_result_t  ld_res_o;
  logic        refill_valid_i;
  addr_t       refill_addr_i;
  logic [31:0] refill_data_i;
  logic        flush_i;

  // program-order word, bytes known so far and residency per line
  logic [31:0] ref_word [LINES];
  logic [3:0]  ref_known [LINES];
  logic        ref_res [LINES];
  exp_load_t   exp_q [$];

  logic [31:0] lcg_state;
  string       test_name;

  lsu_store_path #(
    .DEPTH (DEPTH),
    .IDX_W (IDX_W)
  ) UUT (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .st_valid_i     (st_valid_i),
    .st_req_i       (st_req_i),
    .st_ready_o     (st_ready_o),
    .ld_valid_i     (ld_valid_i),
    .ld_addr_i      (ld_addr_i),
    .ld_valid_o     (ld_valid_o),
    .ld_res_o       (ld_res_o),
    .refill_valid_i (refill_valid_i),
    .refill_addr_i  (refill_addr_i),
    .refill_data_i  (refill_data_i),
    .flush_i        (flush_i)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] byte_mask(input logic [3:0] strb);
    logic [31:0] m;
    for (int b = 0; b < 4; b++)
      m[8*b +: 8] = {8{strb[b]}};
    return m;
  endfunction

  function automatic logic [IDX_W-1:0] line_of(input addr_t a);
    return a[OFFSET_W +: IDX_W];
  endfunction

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // four addresses on lines 5 to 8
  function automatic addr_t pick_addr(input logic [1:0] k);
    return 32'h0000_5014 + 32'h0000_1004 * {30'd0, k};
  endfunction

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic value_error(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
    abort_run();
  endtask

  // next cycle, inputs back to idle
  task automatic tick();
    @(posedge clk);
    #(IN_DELAY);
    st_valid_i     = 1'b0;
    ld_valid_i     = 1'b0;
    refill_valid_i = 1'b0;
    flush_i        = 1'b0;
  endtask

  task automatic send_store(input addr_t a, input logic [31:0] d, input logic [3:0] s);
    logic [IDX_W-1:0] i;
    logic [31:0]      m;
    if (!st_ready_o)
    begin
      $display("store offered while st_ready_o is low");
      abort_run();
    end
    i = line_of(a);
    m = byte_mask(s);
    st_valid_i    = 1'b1;
    st_req_i.addr = a;
    st_req_i.data = d;
    st_req_i.strb = s;
    st_req_i.hit  = 1'b0;
    ref_word[i]  = (ref_word[i] & ~m) | (d & m);
    ref_known[i] = ref_known[i] | s;
  endtask

  // non-resident line only, pending stores land on top of the refill word
  task automatic apply_refill(input addr_t a, input logic [31:0] d);
    logic [IDX_W-1:0] i;
    logic [31:0]      m;
    i = line_of(a);
    m = byte_mask(ref_known[i]);
    refill_valid_i = 1'b1;
    refill_addr_i  = a;
    refill_data_i  = d;
    ref_word[i]  = (ref_word[i] & m) | (d & ~m);
    ref_known[i] = 4'hf;
    ref_res[i]   = 1'b1;
  endtask

  task automatic issue_load(input addr_t a);
    logic [IDX_W-1:0] i;
    exp_load_t        e;
    i = line_of(a);
    e.data = ref_word[i];
    e.mask = ref_res[i] ? 4'hf : ref_known[i];
    e.hit  = ref_res[i] || (ref_known[i] == 4'hf);
    exp_q.push_back(e);
    ld_valid_i = 1'b1;
    ld_addr_i  = a;
  endtask

  // stores on non-resident lines are all still pending
  task automatic raise_flush();
    for (int k = 0; k < LINES; k++)
    begin
      if (!ref_res[k[IDX_W-1:0]])
        ref_known[k[IDX_W-1:0]] = 4'h0;
    end
    flush_i = 1'b1;
  endtask

  task automatic wait_for_ready(input int max_cycles);
    int n;
    n = 0;
    while (!st_ready_o)
    begin
      if (n == max_cycles)
      begin
        $display("st_ready_o did not return within %0d cycles", max_cycles);
        abort_run();
      end
      tick();
      n++;
    end
  endtask

  task automatic wait_loads_done(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0)
    begin
      if (n == max_cycles)
      begin
        $display("load results still missing after %0d cycles", max_cycles);
        abort_run();
      end
      tick();
      n++;
    end
  endtask

  // result valid two edges after the strobe
  assert property (@(posedge clk) disable iff (!arst_n_i)
    ld_valid_o == $past(ld_valid_i, 2))
  else
  begin
    $display("ld_valid_o does not follow ld_valid_i by two cycles");
    abort_run();
  end

  // buffer only fills through an accepted store
  assert property (@(posedge clk) disable iff (!arst_n_i)
    $fell(st_ready_o) |-> $past(st_valid_i && st_ready_o))
  else
  begin
    $display("st_ready_o dropped without a store being accepted");
    abort_run();
  end

  always @(negedge clk)
  begin : load_check
    exp_load_t   e;
    logic [31:0] m;
    if (arst_n_i && ld_valid_o)
    begin
      if (exp_q.size() == 0)
      begin
        $display("load result arrived with no load outstanding");
        abort_run();
      end
      else
      begin
        e = exp_q.pop_front();
        m = byte_mask(e.mask);
        assert ((ld_res_o.data & m) == (e.data & m))
          else value_error("data", e.data & m, ld_res_o.data & m);
        assert (ld_res_o.hit == e.hit)
          else value_error("hit", {31'd0, e.hit}, {31'd0, ld_res_o.hit});
      end
    end
  end

  initial
  begin : watchdog
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in %0d cycles", 2 * TEST_CYCLES);
    abort_run();
  end

  initial
  begin : stimulus
    logic [31:0] r;
    addr_t       a;
    lcg_state      = 32'he26b_ecc7;
    test_name      = "reset_state";
    arst_n_i       = 1'b0;
    st_valid_i     = 1'b0;
    st_req_i       = '0;
    ld_valid_i     = 1'b0;
    ld_addr_i      = '0;
    refill_valid_i = 1'b0;
    refill_addr_i  = '0;
    refill_data_i  = '0;
    flush_i        = 1'b0;
    for (int k = 0; k < LINES; k++)
    begin
      ref_word[k[IDX_W-1:0]]  = '0;
      ref_known[k[IDX_W-1:0]] = 4'h0;
      ref_res[k[IDX_W-1:0]]   = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #(IN_DELAY);
    arst_n_i = 1'b1;

    tick();
    assert (st_ready_o)
      else value_error("st_ready_o", 32'd1, {31'd0, st_ready_o});
    assert (!ld_valid_o)
      else value_error("ld_valid_o", 32'd0, {31'd0, ld_valid_o});
    issue_load(32'h0000_0100);
    tick();
    wait_loads_done(10);

    // partial cover first, then all four bytes
    test_name = "forward_unresident";
    send_store(32'h0000_1004, 32'h1122_3344, 4'b0001);
    tick();
    send_store(32'h0000_1004, 32'h5566_7788, 4'b0100);
    tick();
    issue_load(32'h0000_1004);
    tick();
    send_store(32'h0000_1004, 32'h99aa_bbcc, 4'b1010);
    tick();
    issue_load(32'h0000_1004);
    tick();
    apply_refill(32'h0000_1004, 32'hf0e1_d2c3);
    tick();
    issue_load(32'h0000_1004);
    tick();
    wait_loads_done(10);

    test_name = "backpressure_drain";
    send_store(32'h0000_2008, 32'h0000_00a1, 4'b0001);
    tick();
    send_store(32'h0000_2008, 32'h0000_b2b3, 4'b0011);
    tick();
    send_store(32'h0000_2008, 32'h0000_00c4, 4'b0001);
    tick();
    send_store(32'h0000_2008, 32'h00d5_0000, 4'b0100);
    tick();
    assert (!st_ready_o)
      else value_error("st_ready_o", 32'd0, {31'd0, st_ready_o});
    issue_load(32'h0000_2008);
    tick();
    apply_refill(32'h0000_2008, 32'h7654_3210);
    tick();
    wait_for_ready(20);
    issue_load(32'h0000_2008);
    tick();
    wait_loads_done(10);

    test_name = "youngest_wins";
    apply_refill(32'h0000_300c, 32'h0102_0304);
    tick();
    send_store(32'h0000_300c, 32'hdead_beef, 4'b1111);
    tick();
    send_store(32'h0000_300c, 32'h1234_5678, 4'b0110);
    tick();
    send_store(32'h0000_300c, 32'h00aa_0000, 4'b0100);
    tick();
    issue_load(32'h0000_300c);
    tick();
    // resident stores drain one per cycle
    repeat (DEPTH + 2) tick();
    issue_load(32'h0000_300c);
    tick();
    wait_loads_done(10);

    test_name = "flush_discard";
    send_store(32'h0000_4010, 32'h0bad_f00d, 4'b1111);
    tick();
    send_store(32'h0000_4010, 32'h0011_0022, 4'b0101);
    tick();
    send_store(32'h0000_4010, 32'h3300_0000, 4'b1000);
    tick();
    send_store(32'h0000_4010, 32'h0000_4400, 4'b0010);
    tick();
    // buffer full before the flush
    assert (!st_ready_o)
      else value_error("st_ready_o", 32'd0, {31'd0, st_ready_o});
    issue_load(32'h0000_4010);
    tick();
    raise_flush();
    tick();
    assert (st_ready_o)
      else value_error("st_ready_o", 32'd1, {31'd0, st_ready_o});
    issue_load(32'h0000_4010);
    tick();
    apply_refill(32'h0000_4010, 32'hcafe_0123);
    tick();
    issue_load(32'h0000_4010);
    tick();
    wait_loads_done(10);

    // refill before load before store, as within a cycle
    test_name = "random_mix";
    for (int n = 0; n < RANDOM_CYCLES; n++)
    begin
      r = rand_next();
      a = pick_addr(r[6:5]);
      if (r[4:2] == 3'd0 && !ref_res[line_of(a)])
        apply_refill(a, rand_next());
      if (r[8])
        issue_load(pick_addr(r[10:9]));
      if (r[11] && st_ready_o)
        send_store(pick_addr(r[13:12]), rand_next(), (r[17:14] == 4'h0) ? 4'hf : r[17:14]);
      tick();
    end
    wait_loads_done(10);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* design/lsu_store_path.sv */
// store path top; st_valid_i without st_ready_o is dropped, loads are whole words
`timescale 1ns/1ps
`default_nettype none

module lsu_store_path
  import lsu_pkg::*;
#(
  parameter int DEPTH = SB_DEPTH_DEF,
  parameter int IDX_W = LINE_IDX_W
)
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        st_valid_i,
  input  sb_meta_t    st_req_i,
  output logic        st_ready_o,
  input  logic        ld_valid_i,
  input  addr_t       ld_addr_i,
  output logic        ld_valid_o,
  output ld_result_t  ld_res_o,
  input  logic        refill_valid_i,
  input  addr_t       refill_addr_i,
  input  logic [31:0] refill_data_i,
  input  logic        flush_i
);

  localparam int PTR_W = $clog2(DEPTH);

  sb_meta_t             st_meta;
  logic                 lookup_hit;
  dsram_snoop_t         snoop;
  logic                 commit;
  logic                 top_valid;
  sb_meta_t             top_meta;
  logic [DEPTH-1:0]     sb_valid;
  sb_meta_t [DEPTH-1:0] sb_meta;
  logic [PTR_W-1:0]     sb_top;
  logic [31:0]          arr_word;
  logic                 arr_hit;

  // incoming store takes residency from the tag lookup
  assign st_meta.addr = st_req_i.addr;
  assign st_meta.data = st_req_i.data;
  assign st_meta.strb = st_req_i.strb;
  assign st_meta.hit  = lookup_hit;

  store_buffer #(
    .DEPTH (DEPTH),
    .IDX_W (IDX_W)
  ) u_store_buffer (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .push_i      (st_valid_i),
    .meta_i      (st_meta),
    .ready_o     (st_ready_o),
    .commit_i    (commit),
    .snoop_i     (snoop),
    .valid_o     (sb_valid),
    .meta_o      (sb_meta),
    .top_o       (sb_top),
    .top_valid_o (top_valid),
    .top_meta_o  (top_meta)
  );

  sb_forward #(
    .DEPTH (DEPTH)
  ) u_sb_forward (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .ld_valid_i (ld_valid_i),
    .ld_addr_i  (ld_addr_i),
    .arr_word_i (arr_word),
    .arr_hit_i  (arr_hit),
    .sb_valid_i (sb_valid),
    .sb_meta_i  (sb_meta),
    .sb_top_i   (sb_top),
    .ld_valid_o (ld_valid_o),
    .ld_res_o   (ld_res_o)
  );

  dcache_array #(
    .IDX_W (IDX_W)
  ) u_dcache_array (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .lookup_addr_i  (st_req_i.addr),
    .lookup_hit_o   (lookup_hit),
    .refill_valid_i (refill_valid_i),
    .refill_addr_i  (refill_addr_i),
    .refill_data_i  (refill_data_i),
    .snoop_o        (snoop),
    .top_valid_i    (top_valid),
    .top_meta_i     (top_meta),
    .commit_o       (commit),
    .rd_valid_i     (ld_valid_i),
    .rd_addr_i      (ld_addr_i),
    .rd_word_o      (arr_word),
    .rd_hit_o       (arr_hit)
  );

endmodule

`default_nettype wire

/* design/dcache_array.sv */
// direct-mapped word-per-line array; drain is held off for one cycle on a refill to its line
`timescale 1ns/1ps
`default_nettype none

module dcache_array
  import lsu_pkg::*;
#(
  parameter int IDX_W = LINE_IDX_W
)
(
  input  logic         clk,
  input  logic         arst_n_i,
  input  addr_t        lookup_addr_i,
  output logic         lookup_hit_o,
  input  logic         refill_valid_i,
  input  addr_t        refill_addr_i,
  input  logic [31:0]  refill_data_i,
  output dsram_snoop_t snoop_o,
  input  logic         top_valid_i,
  input  sb_meta_t     top_meta_i,
  output logic         commit_o,
  input  logic         rd_valid_i,
  input  addr_t        rd_addr_i,
  output logic [31:0]  rd_word_o,
  output logic         rd_hit_o
);

  localparam int LINES = 1 << IDX_W;
  localparam int TAG_W = WORD_ADDR_W - IDX_W;

  logic [TAG_W-1:0] tag_q [LINES];
  logic [31:0]      data_q [LINES];
  logic [LINES-1:0] valid_q;

  logic [IDX_W-1:0] lk_idx, rf_idx, dr_idx, rd_idx;
  logic [TAG_W-1:0] lk_tag, rf_tag, rd_tag;

  logic [31:0] rd_word_nxt, rd_word_q;
  logic        rd_hit_nxt, rd_hit_q;

  assign lk_idx = lookup_addr_i[OFFSET_W +: IDX_W];
  assign lk_tag = lookup_addr_i[31 -: TAG_W];
  assign rf_idx = refill_addr_i[OFFSET_W +: IDX_W];
  assign rf_tag = refill_addr_i[31 -: TAG_W];
  assign dr_idx = top_meta_i.addr[OFFSET_W +: IDX_W];
  assign rd_idx = rd_addr_i[OFFSET_W +: IDX_W];
  assign rd_tag = rd_addr_i[31 -: TAG_W];

  assign lookup_hit_o = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

  // refill to the draining line wins, entry retries after the snoop
  assign commit_o = top_valid_i && top_meta_i.hit && !(refill_valid_i && rf_idx == dr_idx);

  assign snoop_o.valid       = refill_valid_i;
  assign snoop_o.idx         = WORD_ADDR_W'(rf_idx);
  assign snoop_o.tag         = WORD_ADDR_W'(rf_tag);
  assign snoop_o.evict_tag   = WORD_ADDR_W'(tag_q[rf_idx]);
  assign snoop_o.evict_valid = valid_q[rf_idx];

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_q <= '0;
    else if (refill_valid_i)
      valid_q[rf_idx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (commit_o)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (top_meta_i.strb[b])
          data_q[dr_idx][8*b +: 8] <= top_meta_i.data[8*b +: 8];
      end
    end
    if (refill_valid_i)
    begin
      data_q[rf_idx] <= refill_data_i;
      tag_q[rf_idx]  <= rf_tag;
    end
  end

  // read sees this cycle's drain and refill writes
  always_comb
  begin
    rd_word_nxt = data_q[rd_idx];
    rd_hit_nxt  = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    if (commit_o && dr_idx == rd_idx)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (top_meta_i.strb[b])
          rd_word_nxt[8*b +: 8] = top_meta_i.data[8*b +: 8];
      end
    end
    if (refill_valid_i && rf_idx == rd_idx)
    begin
      rd_word_nxt = refill_data_i;
      rd_hit_nxt  = (rf_tag == rd_tag);
    end
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      rd_hit_q <= 1'b0;
    else if (rd_valid_i)
      rd_hit_q <= rd_hit_nxt;
  end

  always_ff @(posedge clk)
  begin
    if (rd_valid_i)
      rd_word_q <= rd_word_nxt;
  end

  assign rd_word_o = rd_word_q;
  assign rd_hit_o  = rd_hit_q;

endmodule

`default_nettype wire

/* design/sb_forward.sv */
// two-cycle load merge; forwarded bytes are snapshotted in the strobe cycle
`timescale 1ns/1ps
`default_nettype none

module sb_forward
  import lsu_pkg::*;
#(
  parameter int DEPTH = SB_DEPTH_DEF
)
(
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     ld_valid_i,
  input  addr_t                    ld_addr_i,
  input  logic [31:0]              arr_word_i,
  input  logic                     arr_hit_i,
  input  logic [DEPTH-1:0]         sb_valid_i,
  input  sb_meta_t [DEPTH-1:0]     sb_meta_i,
  input  logic [$clog2(DEPTH)-1:0] sb_top_i,
  output logic                     ld_valid_o,
  output ld_result_t               ld_res_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0] slot;
  logic [31:0]      fwd_data;
  logic [3:0]       fwd_mask;

  logic        s1_valid_q;
  logic [31:0] fwd_data_q;
  logic [3:0]  fwd_mask_q;

  logic       res_valid_q;
  ld_result_t res_q;
  logic [31:0] merged;

  // oldest to youngest so younger strobes overwrite
  always_comb
  begin
    fwd_data = '0;
    fwd_mask = '0;
    slot     = sb_top_i;
    for (int k = 0; k < DEPTH; k++)
    begin
      slot = sb_top_i + PTR_W'(k);
      if (sb_valid_i[slot]
          && sb_meta_i[slot].addr[31:OFFSET_W] == ld_addr_i[31:OFFSET_W])
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (sb_meta_i[slot].strb[b])
          begin
            fwd_data[8*b +: 8] = sb_meta_i[slot].data[8*b +: 8];
            fwd_mask[b]        = 1'b1;
          end
        end
      end
    end
  end

  always_comb
  begin
    merged = arr_word_i;
    for (int b = 0; b < 4; b++)
    begin
      if (fwd_mask_q[b])
        merged[8*b +: 8] = fwd_data_q[8*b +: 8];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      s1_valid_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end
    else
    begin
      s1_valid_q  <= ld_valid_i;
      res_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ld_valid_i)
    begin
      fwd_data_q <= fwd_data;
      fwd_mask_q <= fwd_mask;
    end
    if (s1_valid_q)
    begin
      res_q.data <= merged;
      res_q.hit  <= arr_hit_i || (&fwd_mask_q);
    end
  end

  assign ld_valid_o = res_valid_q;
  assign ld_res_o   = res_q;

endmodule

`default_nettype wire

/* store_buffer/store_buffer.sv */
// circular store FIFO; DEPTH must be a power of two >= 2, pushes while full are dropped
`timescale 1ns/1ps
`default_nettype none

module store_buffer
  import lsu_pkg::*;
#(
  parameter int DEPTH = SB_DEPTH_DEF,
  parameter int IDX_W = LINE_IDX_W
)
(
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  input  logic                     push_i,
  input  sb_meta_t                 meta_i,
  output logic                     ready_o,
  input  logic                     commit_i,
  input  dsram_snoop_t             snoop_i,
  output logic [DEPTH-1:0]         valid_o,
  output sb_meta_t [DEPTH-1:0]     meta_o,
  output logic [$clog2(DEPTH)-1:0] top_o,
  output logic                     top_valid_o,
  output sb_meta_t                 top_meta_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   cnt_q;
  logic             full_q, empty_q;

  logic push, pop;

  // flush cancels both a push and a drain in the same cycle
  assign push = push_i && !full_q && !flush_i;
  assign pop  = commit_i && !empty_q && !flush_i;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end
    else if (flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;

      // push with pop keeps the count
      case ({push, pop})
        2'b10:
        begin
          cnt_q   <= cnt_q + 1'b1;
          full_q  <= (cnt_q == (PTR_W+1)'(DEPTH - 1));
          empty_q <= 1'b0;
        end
        2'b01:
        begin
          cnt_q   <= cnt_q - 1'b1;
          full_q  <= 1'b0;
          empty_q <= (cnt_q == (PTR_W+1)'(1));
        end
        default:
        begin
          cnt_q <= cnt_q;
        end
      endcase
    end
  end

  for (genvar i = 0; i < DEPTH; i++)
  begin : g_entry
    logic load, inval;

    assign load  = push && (wr_ptr_q == PTR_W'(i));
    assign inval = flush_i || (pop && (rd_ptr_q == PTR_W'(i)));

    sb_entry #(
      .IDX_W (IDX_W)
    ) u_entry (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .inval_i  (inval),
      .load_i   (load),
      .meta_i   (meta_i),
      .snoop_i  (snoop_i),
      .valid_o  (valid_o[i]),
      .meta_o   (meta_o[i])
    );
  end

  assign ready_o     = !full_q;
  assign top_o       = rd_ptr_q;
  assign top_valid_o = valid_o[rd_ptr_q] && !flush_i;
  assign top_meta_o  = meta_o[rd_ptr_q];

endmodule

`default_nettype wire

/* store_buffer/sb_entry.sv */
// single store buffer slot; load_i wins over inval_i when both are asserted
`timescale 1ns/1ps
`default_nettype none

module sb_entry
  import lsu_pkg::*;
#(
  parameter int IDX_W = LINE_IDX_W
)
(
  input  logic         clk,
  input  logic         arst_n_i,
  input  logic         inval_i,
  input  logic         load_i,
  input  sb_meta_t     meta_i,
  input  dsram_snoop_t snoop_i,
  output logic         valid_o,
  output sb_meta_t     meta_o
);

  localparam int TAG_W = WORD_ADDR_W - IDX_W;

  logic     valid_q;
  sb_meta_t meta_q;

  // snoop match against incoming and held store
  logic in_set, in_clr;
  logic held_set, held_clr;

  assign in_set = snoop_i.valid
                  && snoop_i.idx[IDX_W-1:0] == meta_i.addr[OFFSET_W +: IDX_W]
                  && snoop_i.tag[TAG_W-1:0] == meta_i.addr[31 -: TAG_W];
  assign in_clr = snoop_i.valid && snoop_i.evict_valid
                  && snoop_i.idx[IDX_W-1:0] == meta_i.addr[OFFSET_W +: IDX_W]
                  && snoop_i.evict_tag[TAG_W-1:0] == meta_i.addr[31 -: TAG_W];

  assign held_set = snoop_i.valid
                    && snoop_i.idx[IDX_W-1:0] == meta_q.addr[OFFSET_W +: IDX_W]
                    && snoop_i.tag[TAG_W-1:0] == meta_q.addr[31 -: TAG_W];
  assign held_clr = snoop_i.valid && snoop_i.evict_valid
                    && snoop_i.idx[IDX_W-1:0] == meta_q.addr[OFFSET_W +: IDX_W]
                    && snoop_i.evict_tag[TAG_W-1:0] == meta_q.addr[31 -: TAG_W];

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_q <= 1'b0;
    else if (load_i)
      valid_q <= 1'b1;
    else if (inval_i)
      valid_q <= 1'b0;
  end

  // refill of the same line sets hit, eviction clears it
  always_ff @(posedge clk)
  begin
    if (load_i)
    begin
      meta_q     <= meta_i;
      meta_q.hit <= (meta_i.hit && !in_clr) || in_set;
    end
    else if (valid_q)
      meta_q.hit <= (meta_q.hit && !held_clr) || held_set;
  end

  assign valid_o = valid_q;
  assign meta_o  = meta_q;

endmodule

`default_nettype wire

/* common/lsu_pkg.sv */
// shared LSU store-path types; snoop index and tags are zero-extended into 30-bit fields
`default_nettype none

package lsu_pkg;

  // byte offset within a 32-bit word
  localparam int OFFSET_W = 2;
  // word address bits above the byte offset
  localparam int WORD_ADDR_W = 32 - OFFSET_W;

  // default line index width, 16 lines
  localparam int LINE_IDX_W = 4;

  // default store buffer depth, power of two
  localparam int SB_DEPTH_DEF = 4;

  typedef logic [31:0] addr_t;

  // one retired store
  typedef struct packed {
    addr_t       addr;
    logic [31:0] data;
    logic [3:0]  strb;
    // line resident in the data array
    logic        hit;
  } sb_meta_t;

  // broadcast on every refill
  // idx and tags are right-aligned, upper bits zero
  typedef struct packed {
    logic                   valid;
    logic [WORD_ADDR_W-1:0] idx;
    logic [WORD_ADDR_W-1:0] tag;
    logic [WORD_ADDR_W-1:0] evict_tag;
    logic                   evict_valid;
  } dsram_snoop_t;

  // load result, hit set when resident or fully forwarded
  typedef struct packed {
    logic [31:0] data;
    logic        hit;
  } ld_result_t;

endpackage

`default_nettype wire
